/* src/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;

	// top bit is the wrap bit
	typedef logic [5:0] rob_idx_t;
	typedef logic [5:0] prf_tag_t;

	// one bit per unresolved branch
	typedef logic [3:0] br_mask_t;

	// missing load waiting for the miss handler to take it
	typedef enum logic {
		LD_IDLE,
		LD_BUSY
	} ld_hold_e;

endpackage

`default_nettype wire

/* src/sq_lookup_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface sq_lookup_if #(
	parameter int SQ_IDX_W = 3
);
	import lsq_pkg::*;

	// executing load
	addr_t ld_addr;
	logic [SQ_IDX_W-1:0] ld_position;

	// search results, valid in the same cycle
	logic fwd_vld;
	data_t fwd_data;
	logic older_known;

	modport sq (
		input ld_addr,
		input ld_position,
		output fwd_vld,
		output fwd_data,
		output older_known
	);

	modport ctrl (
		output ld_addr,
		output ld_position,
		input fwd_vld,
		input fwd_data,
		input older_known
	);

endinterface

`default_nettype wire

/* src/lq_alloc_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface lq_alloc_if;
	import lsq_pkg::*;

	// one-cycle strobe, tail entry written at the next edge
	logic alloc_en;
	addr_t alloc_addr;
	rob_idx_t alloc_rob_idx;
	prf_tag_t alloc_dest_tag;
	br_mask_t alloc_br_mask;
	logic full;

	modport ctrl (
		output alloc_en,
		output alloc_addr,
		output alloc_rob_idx,
		output alloc_dest_tag,
		output alloc_br_mask,
		input full
	);

	modport lq (
		input alloc_en,
		input alloc_addr,
		input alloc_rob_idx,
		input alloc_dest_tag,
		input alloc_br_mask,
		output full
	);

endinterface

`default_nettype wire

/* src/store_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module store_queue #(
	parameter int SQ_DEPTH = 8,
	localparam int SQ_IDX_W = $clog2(SQ_DEPTH)
) (
	input logic clk,
	input logic rst,
	input logic dp_en_i,
	input logic st_vld_i,
	input logic [SQ_IDX_W-1:0] sq_idx_i,
	input lsq_pkg::addr_t addr_i,
	input lsq_pkg::data_t st_data_i,
	input logic rob_st_retire_en_i,
	input logic mshr_st_ack_i,
	input logic br_recovery_i,
	input logic [SQ_IDX_W:0] sq_tail_recovery_i,
	input logic [SQ_IDX_W-1:0] rs_ld_position_i,
	sq_lookup_if.sq lookup,
	output logic [SQ_IDX_W:0] sq_tail_o,
	output logic sq_full_o,
	output lsq_pkg::addr_t dc_st_addr_o,
	output lsq_pkg::data_t dc_st_data_o,
	output logic dc_st_en_o
);
	import lsq_pkg::*;

	addr_t st_addr [SQ_DEPTH];
	data_t st_data [SQ_DEPTH];
	logic [SQ_DEPTH-1:0] addr_vld;
	logic [SQ_DEPTH-1:0] retire_rdy;

	logic [SQ_IDX_W:0] head_q;
	logic [SQ_IDX_W:0] retire_head_q;
	logic [SQ_IDX_W:0] tail_q;
	logic [SQ_IDX_W-1:0] head_idx;
	logic [SQ_IDX_W-1:0] tail_idx;
	logic drain;

	// number of entries older than the load
	logic [SQ_IDX_W:0] rs_span;
	logic [SQ_IDX_W:0] ex_span;

	assign head_idx = head_q[SQ_IDX_W-1:0];
	assign tail_idx = tail_q[SQ_IDX_W-1:0];

	assign sq_tail_o = tail_q;
	assign sq_full_o = (head_idx == tail_idx) && (head_q[SQ_IDX_W] != tail_q[SQ_IDX_W]);

	// ********************
	// drain to the cache

	assign dc_st_en_o = retire_rdy[head_idx];
	assign dc_st_addr_o = st_addr[head_idx];
	assign dc_st_data_o = st_data[head_idx];
	assign drain = dc_st_en_o && mshr_st_ack_i;

	always_ff @(posedge clk) begin
		if (st_vld_i) begin
			st_addr[sq_idx_i] <= addr_i;
			st_data[sq_idx_i] <= st_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			retire_head_q <= '0;
			tail_q <= '0;
			addr_vld <= '0;
			retire_rdy <= '0;
		end else begin
			if (br_recovery_i)
				tail_q <= sq_tail_recovery_i;
			else if (dp_en_i)
				tail_q <= tail_q + 1'b1;
			if (dp_en_i)
				addr_vld[tail_idx] <= 1'b0;
			if (st_vld_i)
				addr_vld[sq_idx_i] <= 1'b1;
			if (rob_st_retire_en_i) begin
				retire_rdy[retire_head_q[SQ_IDX_W-1:0]] <= 1'b1;
				retire_head_q <= retire_head_q + 1'b1;
			end
			if (drain) begin
				addr_vld[head_idx] <= 1'b0;
				retire_rdy[head_idx] <= 1'b0;
				head_q <= head_q + 1'b1;
			end
		end
	end

	// ********************
	// age search

	// load sitting at the tail of a full queue is behind every entry
	assign rs_span = (sq_full_o && rs_ld_position_i == tail_idx) ?
		(SQ_IDX_W+1)'(SQ_DEPTH) : {1'b0, rs_ld_position_i - head_idx};
	assign ex_span = (sq_full_o && lookup.ld_position == tail_idx) ?
		(SQ_IDX_W+1)'(SQ_DEPTH) : {1'b0, lookup.ld_position - head_idx};

	always_comb begin
		logic [SQ_IDX_W-1:0] slot;
		slot = head_idx;
		lookup.older_known = 1'b1;
		lookup.fwd_vld = 1'b0;
		lookup.fwd_data = '0;
		// walk oldest first so the youngest match is kept
		for (int k = 0; k < SQ_DEPTH; k++) begin
			slot = head_idx + SQ_IDX_W'(k);
			if (k < int'(rs_span) && !addr_vld[slot])
				lookup.older_known = 1'b0;
			if (k < int'(ex_span) && addr_vld[slot] && st_addr[slot] == lookup.ld_addr) begin
				lookup.fwd_vld = 1'b1;
				lookup.fwd_data = st_data[slot];
			end
		end
	end

	// dispatch stalls on sq_full_o
	dispatch_not_full: assert property (@(posedge clk) disable iff (rst)
		dp_en_i |-> !sq_full_o);

endmodule

`default_nettype wire

/* src/load_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module load_queue #(
	parameter int LQ_DEPTH = 4,
	localparam int LQ_IDX_W = $clog2(LQ_DEPTH)
) (
	input logic clk,
	input logic rst,
	input logic mshr_vld_i,
	input lsq_pkg::addr_t mshr_addr_i,
	input lsq_pkg::data_t dc_data_i,
	input logic br_recovery_i,
	input logic br_pred_correct_i,
	input lsq_pkg::br_mask_t br_tag_fix_i,
	lq_alloc_if.lq alloc,
	output logic lq_com_rdy_o,
	output lsq_pkg::data_t com_data_o,
	output lsq_pkg::rob_idx_t com_rob_idx_o,
	output lsq_pkg::prf_tag_t com_dest_tag_o,
	output lsq_pkg::br_mask_t com_br_mask_o
);
	import lsq_pkg::*;

	addr_t lq_addr [LQ_DEPTH];
	rob_idx_t lq_rob_idx [LQ_DEPTH];
	prf_tag_t lq_dest_tag [LQ_DEPTH];
	br_mask_t lq_br_mask [LQ_DEPTH];
	data_t lq_data [LQ_DEPTH];
	logic [LQ_DEPTH-1:0] lq_vld;
	logic [LQ_DEPTH-1:0] lq_rdy;

	logic [LQ_IDX_W:0] head_q;
	logic [LQ_IDX_W:0] tail_q;
	logic [LQ_IDX_W-1:0] head_idx;
	logic [LQ_IDX_W-1:0] tail_idx;
	logic not_empty;
	logic head_fill;
	logic head_done;
	logic head_kill;
	logic head_adv;
	br_mask_t fix_mask;

	assign head_idx = head_q[LQ_IDX_W-1:0];
	assign tail_idx = tail_q[LQ_IDX_W-1:0];
	assign not_empty = head_q != tail_q;
	assign alloc.full = (head_idx == tail_idx) && (head_q[LQ_IDX_W] != tail_q[LQ_IDX_W]);

	// bits resolved as correctly predicted this cycle
	assign fix_mask = br_pred_correct_i ? br_tag_fix_i : '0;

	// ********************
	// head completion

	// fill for the head bypasses the data array
	assign head_fill = mshr_vld_i && (mshr_addr_i == lq_addr[head_idx]);
	assign head_done = not_empty && (head_fill || lq_rdy[head_idx]);
	assign head_kill = br_recovery_i && ((lq_br_mask[head_idx] & br_tag_fix_i) != '0);
	// squashed entries leave without a writeback
	assign head_adv = head_done || (not_empty && !lq_vld[head_idx]);

	assign lq_com_rdy_o = head_done && lq_vld[head_idx] && !head_kill;
	assign com_data_o = head_fill ? dc_data_i : lq_data[head_idx];
	assign com_rob_idx_o = lq_rob_idx[head_idx];
	assign com_dest_tag_o = lq_dest_tag[head_idx];
	assign com_br_mask_o = lq_br_mask[head_idx] & ~fix_mask;

	// ********************
	// entry update

	always_ff @(posedge clk) begin
		if (alloc.alloc_en) begin
			lq_addr[tail_idx] <= alloc.alloc_addr;
			lq_rob_idx[tail_idx] <= alloc.alloc_rob_idx;
			lq_dest_tag[tail_idx] <= alloc.alloc_dest_tag;
		end
		for (int k = 0; k < LQ_DEPTH; k++) begin
			lq_br_mask[k] <= lq_br_mask[k] & ~fix_mask;
			if (mshr_vld_i && mshr_addr_i == lq_addr[k])
				lq_data[k] <= dc_data_i;
		end
		if (alloc.alloc_en)
			lq_br_mask[tail_idx] <= alloc.alloc_br_mask & ~fix_mask;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_q <= '0;
			tail_q <= '0;
			lq_vld <= '0;
			lq_rdy <= '0;
		end else begin
			for (int k = 0; k < LQ_DEPTH; k++) begin
				if (mshr_vld_i && mshr_addr_i == lq_addr[k])
					lq_rdy[k] <= 1'b1;
				if (br_recovery_i && (lq_br_mask[k] & br_tag_fix_i) != '0)
					lq_vld[k] <= 1'b0;
			end
			if (alloc.alloc_en) begin
				// load already under the branch being recovered
				lq_vld[tail_idx] <= !(br_recovery_i &&
					(alloc.alloc_br_mask & br_tag_fix_i) != '0);
				lq_rdy[tail_idx] <= 1'b0;
				tail_q <= tail_q + 1'b1;
			end
			if (head_adv)
				head_q <= head_q + 1'b1;
		end
	end

	// issue logic keeps loads back while the queue is full
	alloc_not_full: assert property (@(posedge clk) disable iff (rst)
		alloc.alloc_en |-> !alloc.full);

endmodule

`default_nettype wire

/* src/lsq_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module lsq_ctrl #(
	parameter int SQ_IDX_W = 3
) (
	input logic clk,
	input logic rst,
	input logic ld_vld_i,
	input lsq_pkg::addr_t addr_i,
	input logic [SQ_IDX_W-1:0] ex_ld_position_i,
	input lsq_pkg::rob_idx_t rob_idx_i,
	input lsq_pkg::prf_tag_t dest_tag_i,
	input lsq_pkg::br_mask_t br_mask_i,
	input logic dc_hit_i,
	input lsq_pkg::data_t dc_data_i,
	input logic mshr_ld_ack_i,
	input logic mshr_vld_i,
	input logic mshr_stall_i,
	input logic lq_com_rdy_i,
	input lsq_pkg::data_t com_data_i,
	input lsq_pkg::rob_idx_t com_rob_idx_i,
	input lsq_pkg::prf_tag_t com_dest_tag_i,
	input lsq_pkg::br_mask_t com_br_mask_i,
	sq_lookup_if.ctrl lookup,
	lq_alloc_if.ctrl alloc,
	output logic ld_iss_en_o,
	output lsq_pkg::addr_t dc_ld_addr_o,
	output logic dc_ld_en_o,
	output logic ld_done_o,
	output lsq_pkg::data_t ld_data_o,
	output lsq_pkg::rob_idx_t ld_rob_idx_o,
	output lsq_pkg::prf_tag_t ld_dest_tag_o,
	output lsq_pkg::br_mask_t ld_br_mask_o
);
	import lsq_pkg::*;

	ld_hold_e state_q;
	ld_hold_e state_nxt;
	addr_t hold_addr;
	rob_idx_t hold_rob_idx;
	prf_tag_t hold_dest_tag;
	br_mask_t hold_br_mask;
	logic wb_busy;
	logic need_mem;

	assign lookup.ld_addr = addr_i;
	assign lookup.ld_position = ex_ld_position_i;

	// ********************
	// hit, forward or miss

	// writeback port taken by a fill or by the load queue head
	assign wb_busy = mshr_vld_i || lq_com_rdy_i;
	assign ld_done_o = ld_vld_i && (lookup.fwd_vld || dc_hit_i) && !wb_busy;
	assign need_mem = (ld_vld_i && !ld_done_o) || (state_q == LD_BUSY);

	assign dc_ld_en_o = need_mem;
	assign dc_ld_addr_o = ld_vld_i ? addr_i : hold_addr;

	assign alloc.alloc_en = need_mem && mshr_ld_ack_i;
	assign alloc.alloc_addr = dc_ld_addr_o;
	assign alloc.alloc_rob_idx = ld_vld_i ? rob_idx_i : hold_rob_idx;
	assign alloc.alloc_dest_tag = ld_vld_i ? dest_tag_i : hold_dest_tag;
	assign alloc.alloc_br_mask = ld_vld_i ? br_mask_i : hold_br_mask;

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			LD_IDLE: begin
				if (need_mem && !mshr_ld_ack_i)
					state_nxt = LD_BUSY;
			end
			LD_BUSY: begin
				if (mshr_ld_ack_i)
					state_nxt = LD_IDLE;
			end
			default: state_nxt = LD_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= LD_IDLE;
		else
			state_q <= state_nxt;
	end

	// fields kept for re-requesting
	always_ff @(posedge clk) begin
		if (ld_vld_i) begin
			hold_addr <= addr_i;
			hold_rob_idx <= rob_idx_i;
			hold_dest_tag <= dest_tag_i;
			hold_br_mask <= br_mask_i;
		end
	end

	// no new load while one is held or about to be
	assign ld_iss_en_o = lookup.older_known && !alloc.full && !mshr_stall_i &&
		(state_nxt == LD_IDLE);

	// ********************
	// writeback mux, load queue first

	assign ld_data_o = lq_com_rdy_i ? com_data_i :
		lookup.fwd_vld ? lookup.fwd_data : dc_data_i;
	assign ld_rob_idx_o = lq_com_rdy_i ? com_rob_idx_i : rob_idx_i;
	assign ld_dest_tag_o = lq_com_rdy_i ? com_dest_tag_i : dest_tag_i;
	assign ld_br_mask_o = lq_com_rdy_i ? com_br_mask_i : br_mask_i;

	// issue is held back until the held load is taken
	no_load_while_held: assert property (@(posedge clk) disable iff (rst)
		ld_vld_i |-> state_q == LD_IDLE);

endmodule

`default_nettype wire

/* src/lsq_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsq_top #(
	parameter int SQ_DEPTH = 8,
	parameter int LQ_DEPTH = 4,
	localparam int SQ_IDX_W = $clog2(SQ_DEPTH)
) (
	input logic clk,
	input logic rst,

	// store dispatch and execution
	input logic dp_en_i,
	input logic st_vld_i,
	input logic [SQ_IDX_W-1:0] sq_idx_i,
	input lsq_pkg::addr_t addr_i,
	input lsq_pkg::data_t st_data_i,
	input logic rob_st_retire_en_i,

	// loads
	input logic ld_vld_i,
	input logic [SQ_IDX_W-1:0] rs_ld_position_i,
	input logic [SQ_IDX_W-1:0] ex_ld_position_i,
	input lsq_pkg::rob_idx_t rob_idx_i,
	input lsq_pkg::prf_tag_t dest_tag_i,
	input lsq_pkg::br_mask_t br_mask_i,

	// data cache and miss handler
	input logic dc_hit_i,
	input lsq_pkg::data_t dc_data_i,
	input logic mshr_ld_ack_i,
	input logic mshr_st_ack_i,
	input logic mshr_vld_i,
	input lsq_pkg::addr_t mshr_addr_i,
	input logic mshr_stall_i,

	// branches
	input logic br_recovery_i,
	input logic br_pred_correct_i,
	input lsq_pkg::br_mask_t br_tag_fix_i,
	input logic [SQ_IDX_W:0] sq_tail_recovery_i,

	output logic [SQ_IDX_W:0] sq_tail_o,
	output logic sq_full_o,
	output logic ld_iss_en_o,
	output lsq_pkg::addr_t dc_ld_addr_o,
	output logic dc_ld_en_o,
	output lsq_pkg::addr_t dc_st_addr_o,
	output lsq_pkg::data_t dc_st_data_o,
	output logic dc_st_en_o,
	output logic ld_done_o,
	output lsq_pkg::data_t ld_data_o,
	output lsq_pkg::rob_idx_t ld_rob_idx_o,
	output lsq_pkg::prf_tag_t ld_dest_tag_o,
	output lsq_pkg::br_mask_t ld_br_mask_o,
	output logic lq_com_rdy_o
);
	import lsq_pkg::*;

	data_t com_data;
	rob_idx_t com_rob_idx;
	prf_tag_t com_dest_tag;
	br_mask_t com_br_mask;

	sq_lookup_if #(.SQ_IDX_W(SQ_IDX_W)) lookup_if ();
	lq_alloc_if alloc_if ();

	store_queue #(
		.SQ_DEPTH(SQ_DEPTH)
	) i_store_queue (
		.clk(clk),
		.rst(rst),
		.dp_en_i(dp_en_i),
		.st_vld_i(st_vld_i),
		.sq_idx_i(sq_idx_i),
		.addr_i(addr_i),
		.st_data_i(st_data_i),
		.rob_st_retire_en_i(rob_st_retire_en_i),
		.mshr_st_ack_i(mshr_st_ack_i),
		.br_recovery_i(br_recovery_i),
		.sq_tail_recovery_i(sq_tail_recovery_i),
		.rs_ld_position_i(rs_ld_position_i),
		.lookup(lookup_if.sq),
		.sq_tail_o(sq_tail_o),
		.sq_full_o(sq_full_o),
		.dc_st_addr_o(dc_st_addr_o),
		.dc_st_data_o(dc_st_data_o),
		.dc_st_en_o(dc_st_en_o)
	);

	load_queue #(
		.LQ_DEPTH(LQ_DEPTH)
	) i_load_queue (
		.clk(clk),
		.rst(rst),
		.mshr_vld_i(mshr_vld_i),
		.mshr_addr_i(mshr_addr_i),
		.dc_data_i(dc_data_i),
		.br_recovery_i(br_recovery_i),
		.br_pred_correct_i(br_pred_correct_i),
		.br_tag_fix_i(br_tag_fix_i),
		.alloc(alloc_if.lq),
		.lq_com_rdy_o(lq_com_rdy_o),
		.com_data_o(com_data),
		.com_rob_idx_o(com_rob_idx),
		.com_dest_tag_o(com_dest_tag),
		.com_br_mask_o(com_br_mask)
	);

	lsq_ctrl #(
		.SQ_IDX_W(SQ_IDX_W)
	) i_lsq_ctrl (
		.clk(clk),
		.rst(rst),
		.ld_vld_i(ld_vld_i),
		.addr_i(addr_i),
		.ex_ld_position_i(ex_ld_position_i),
		.rob_idx_i(rob_idx_i),
		.dest_tag_i(dest_tag_i),
		.br_mask_i(br_mask_i),
		.dc_hit_i(dc_hit_i),
		.dc_data_i(dc_data_i),
		.mshr_ld_ack_i(mshr_ld_ack_i),
		.mshr_vld_i(mshr_vld_i),
		.mshr_stall_i(mshr_stall_i),
		.lq_com_rdy_i(lq_com_rdy_o),
		.com_data_i(com_data),
		.com_rob_idx_i(com_rob_idx),
		.com_dest_tag_i(com_dest_tag),
		.com_br_mask_i(com_br_mask),
		.lookup(lookup_if.ctrl),
		.alloc(alloc_if.ctrl),
		.ld_iss_en_o(ld_iss_en_o),
		.dc_ld_addr_o(dc_ld_addr_o),
		.dc_ld_en_o(dc_ld_en_o),
		.ld_done_o(ld_done_o),
		.ld_data_o(ld_data_o),
		.ld_rob_idx_o(ld_rob_idx_o),
		.ld_dest_tag_o(ld_dest_tag_o),
		.ld_br_mask_o(ld_br_mask_o)
	);

endmodule

`default_nettype wire

/* testbench/lsq_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsq_tb;
	import lsq_pkg::*;

	localparam int HALF_PERIOD = 2;
	localparam int CLK_PERIOD = 2 * HALF_PERIOD;
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES = 3000;
	localparam int NUM_TESTS = 3;
	localparam int WATCHDOG_NS = (NUM_TESTS * TEST_CYCLES + RESET_CYCLES + 500) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic dp_en, st_vld, rob_st_retire_en, ld_vld, dc_hit;
	logic mshr_ld_ack, mshr_st_ack, mshr_vld, mshr_stall;
	logic br_recovery, br_pred_correct;
	logic [2:0] sq_idx, rs_pos, ex_pos;
	logic [3:0] sq_tail_recovery;
	addr_t addr, mshr_addr;
	data_t st_data, dc_data;
	rob_idx_t rob_idx;
	prf_tag_t dest_tag;
	br_mask_t br_mask, br_tag_fix;

	logic [3:0] sq_tail;
	logic sq_full, ld_iss_en, dc_ld_en, dc_st_en, ld_done, lq_com_rdy;
	addr_t dc_ld_addr, dc_st_addr;
	data_t dc_st_data, ld_data;
	rob_idx_t ld_rob_idx;
	prf_tag_t ld_dest_tag;
	br_mask_t ld_br_mask;

	// ********************
	// reference model state

	addr_t m_st_addr [8];
	data_t m_st_data [8];
	logic [7:0] m_av, m_ret;
	logic [3:0] m_head, m_rhead, m_tail;
	addr_t q_addr [4];
	rob_idx_t q_rob [4];
	prf_tag_t q_tag [4];
	br_mask_t q_mask [4];
	data_t q_data [4];
	logic [3:0] q_vld, q_rdy;
	logic [2:0] q_head, q_tail;
	logic m_busy;
	addr_t h_addr;
	rob_idx_t h_rob;
	prf_tag_t h_tag;
	br_mask_t h_mask;

	// predictions for the current cycle
	logic e_drain, e_alloc, e_head_adv, e_busy_n, e_iss_en;
	addr_t e_ld_addr;

	addr_t pool [8];
	int ld_ack_pct, st_ack_pct, br_pct, fill_pct;
	int errors, test_errors, checks;

	lsq_top i_dut (
		.clk(clk), .rst(rst),
		.dp_en_i(dp_en), .st_vld_i(st_vld), .sq_idx_i(sq_idx), .addr_i(addr),
		.st_data_i(st_data), .rob_st_retire_en_i(rob_st_retire_en),
		.ld_vld_i(ld_vld), .rs_ld_position_i(rs_pos), .ex_ld_position_i(ex_pos),
		.rob_idx_i(rob_idx), .dest_tag_i(dest_tag), .br_mask_i(br_mask),
		.dc_hit_i(dc_hit), .dc_data_i(dc_data), .mshr_ld_ack_i(mshr_ld_ack),
		.mshr_st_ack_i(mshr_st_ack), .mshr_vld_i(mshr_vld), .mshr_addr_i(mshr_addr),
		.mshr_stall_i(mshr_stall), .br_recovery_i(br_recovery),
		.br_pred_correct_i(br_pred_correct), .br_tag_fix_i(br_tag_fix),
		.sq_tail_recovery_i(sq_tail_recovery),
		.sq_tail_o(sq_tail), .sq_full_o(sq_full), .ld_iss_en_o(ld_iss_en),
		.dc_ld_addr_o(dc_ld_addr), .dc_ld_en_o(dc_ld_en), .dc_st_addr_o(dc_st_addr),
		.dc_st_data_o(dc_st_data), .dc_st_en_o(dc_st_en), .ld_done_o(ld_done),
		.ld_data_o(ld_data), .ld_rob_idx_o(ld_rob_idx), .ld_dest_tag_o(ld_dest_tag),
		.ld_br_mask_o(ld_br_mask), .lq_com_rdy_o(lq_com_rdy)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic reset_model();
		m_av = '0;
		m_ret = '0;
		m_head = '0;
		m_rhead = '0;
		m_tail = '0;
		q_vld = '0;
		q_rdy = '0;
		q_head = '0;
		q_tail = '0;
		m_busy = 1'b0;
		for (int k = 0; k < 8; k++) begin
			m_st_addr[k] = '0;
			m_st_data[k] = '0;
		end
		for (int k = 0; k < 4; k++) begin
			q_addr[k] = '0;
			q_mask[k] = '0;
			q_data[k] = '0;
		end
	endtask

	// ********************
	// expected outputs from model state and current inputs

	task automatic predict_and_check();
		logic [2:0] hs;
		logic [2:0] slot;
		logic [1:0] lh;
		logic full, known, fwd, nonempty, head_fill, head_done, kill, com, done;
		logic need_mem;
		int rs_older, ex_older;
		data_t fwd_data;
		br_mask_t fix;
		hs = m_head[2:0];
		lh = q_head[1:0];
		full = (m_tail - m_head) == 4'd8;
		rs_older = (full && rs_pos == m_tail[2:0]) ? 8 : int'(3'(rs_pos - hs));
		ex_older = (full && ex_pos == m_tail[2:0]) ? 8 : int'(3'(ex_pos - hs));
		known = 1'b1;
		fwd = 1'b0;
		fwd_data = '0;
		for (int k = 0; k < rs_older; k++) begin
			if (!m_av[3'(hs + 3'(k))])
				known = 1'b0;
		end
		// youngest older store first
		for (int k = ex_older - 1; k >= 0; k--) begin
			slot = 3'(hs + 3'(k));
			if (!fwd && m_av[slot] && m_st_addr[slot] == addr) begin
				fwd = 1'b1;
				fwd_data = m_st_data[slot];
			end
		end
		nonempty = q_head != q_tail;
		head_fill = mshr_vld && mshr_addr == q_addr[lh];
		head_done = nonempty && (head_fill || q_rdy[lh]);
		kill = br_recovery && (q_mask[lh] & br_tag_fix) != '0;
		com = head_done && q_vld[lh] && !kill;
		e_head_adv = head_done || (nonempty && !q_vld[lh]);
		done = ld_vld && (fwd || dc_hit) && !(mshr_vld || com);
		need_mem = (ld_vld && !done) || m_busy;
		e_ld_addr = ld_vld ? addr : h_addr;
		e_alloc = need_mem && mshr_ld_ack;
		e_busy_n = need_mem && !mshr_ld_ack;
		e_iss_en = known && (q_tail - q_head) != 3'd4 && !mshr_stall && !e_busy_n;
		e_drain = m_ret[hs] && mshr_st_ack;
		fix = br_pred_correct ? br_tag_fix : '0;

		check_value("sq_tail_o", 64'(sq_tail), 64'(m_tail));
		check_value("sq_full_o", 64'(sq_full), 64'(full));
		check_value("dc_st_en_o", 64'(dc_st_en), 64'(m_ret[hs]));
		if (m_ret[hs]) begin
			check_value("dc_st_addr_o", 64'(dc_st_addr), 64'(m_st_addr[hs]));
			check_value("dc_st_data_o", dc_st_data, m_st_data[hs]);
		end
		check_value("ld_iss_en_o", 64'(ld_iss_en), 64'(e_iss_en));
		check_value("dc_ld_en_o", 64'(dc_ld_en), 64'(need_mem));
		if (need_mem)
			check_value("dc_ld_addr_o", 64'(dc_ld_addr), 64'(e_ld_addr));
		check_value("ld_done_o", 64'(ld_done), 64'(done));
		check_value("lq_com_rdy_o", 64'(lq_com_rdy), 64'(com));
		if (com) begin
			check_value("ld_data_o", ld_data, head_fill ? dc_data : q_data[lh]);
			check_value("ld_rob_idx_o", 64'(ld_rob_idx), 64'(q_rob[lh]));
			check_value("ld_dest_tag_o", 64'(ld_dest_tag), 64'(q_tag[lh]));
			check_value("ld_br_mask_o", 64'(ld_br_mask), 64'(q_mask[lh] & ~fix));
		end else if (done) begin
			check_value("ld_data_o", ld_data, fwd ? fwd_data : dc_data);
			check_value("ld_rob_idx_o", 64'(ld_rob_idx), 64'(rob_idx));
			check_value("ld_dest_tag_o", 64'(ld_dest_tag), 64'(dest_tag));
			check_value("ld_br_mask_o", 64'(ld_br_mask), 64'(br_mask));
		end
	endtask

	// ********************
	// model update at the clock edge

	task automatic advance_model();
		logic [2:0] ts;
		logic [1:0] tq;
		br_mask_t fix;
		br_mask_t m;
		ts = m_tail[2:0];
		fix = br_pred_correct ? br_tag_fix : '0;
		if (dp_en)
			m_av[ts] = 1'b0;
		if (st_vld) begin
			m_av[sq_idx] = 1'b1;
			m_st_addr[sq_idx] = addr;
			m_st_data[sq_idx] = st_data;
		end
		if (rob_st_retire_en) begin
			m_ret[m_rhead[2:0]] = 1'b1;
			m_rhead = m_rhead + 4'd1;
		end
		if (e_drain) begin
			m_av[m_head[2:0]] = 1'b0;
			m_ret[m_head[2:0]] = 1'b0;
			m_head = m_head + 4'd1;
		end
		if (br_recovery)
			m_tail = sq_tail_recovery;
		else if (dp_en)
			m_tail = m_tail + 4'd1;

		for (int k = 0; k < 4; k++) begin
			if (br_recovery && (q_mask[k] & br_tag_fix) != '0)
				q_vld[k] = 1'b0;
			q_mask[k] = q_mask[k] & ~fix;
			if (mshr_vld && mshr_addr == q_addr[k]) begin
				q_rdy[k] = 1'b1;
				q_data[k] = dc_data;
			end
		end
		if (e_alloc) begin
			tq = q_tail[1:0];
			m = ld_vld ? br_mask : h_mask;
			q_addr[tq] = e_ld_addr;
			q_rob[tq] = ld_vld ? rob_idx : h_rob;
			q_tag[tq] = ld_vld ? dest_tag : h_tag;
			q_mask[tq] = m & ~fix;
			q_vld[tq] = !(br_recovery && (m & br_tag_fix) != '0);
			q_rdy[tq] = 1'b0;
			q_tail = q_tail + 3'd1;
		end
		if (e_head_adv)
			q_head = q_head + 3'd1;
		if (ld_vld) begin
			h_addr = addr;
			h_rob = rob_idx;
			h_tag = dest_tag;
			h_mask = br_mask;
		end
		m_busy = e_busy_n;
	endtask

	// ********************
	// stimulus, acting as cache and reorder buffer

	task automatic drive_inputs();
		int cnt;
		int unret;
		int k;
		logic rec;
		logic [2:0] slot;
		cnt = int'(4'(m_tail - m_head));
		rec = ($urandom % 100) < br_pct;
		br_recovery <= rec;
		br_pred_correct <= !rec && ($urandom % 100) < br_pct;
		br_tag_fix <= 4'(1 << ($urandom % 4));
		if (rec) begin
			unret = int'(4'(m_tail - m_rhead));
			sq_tail_recovery <= m_tail - 4'($urandom % (unret + 1));
		end
		dp_en <= !rec && cnt < 8 && ($urandom % 2) == 0;
		rob_st_retire_en <= !rec && m_rhead != m_tail && m_av[m_rhead[2:0]] &&
			($urandom % 2) == 0;
		ld_vld <= 1'b0;
		st_vld <= 1'b0;
		if (e_iss_en && ($urandom % 3) == 0) begin
			ld_vld <= 1'b1;
			ex_pos <= rs_pos;
			addr <= pool[$urandom % 8];
			rob_idx <= 6'($urandom);
			dest_tag <= 6'($urandom);
			br_mask <= 4'($urandom);
			dc_hit <= ($urandom % 2) == 0;
		end else if (cnt > 0) begin
			slot = 3'(m_head[2:0] + 3'($urandom % cnt));
			if (!m_av[slot]) begin
				st_vld <= 1'b1;
				sq_idx <= slot;
				addr <= pool[$urandom % 8];
				st_data <= {$urandom, $urandom};
			end
		end
		mshr_st_ack <= ($urandom % 100) < st_ack_pct;
		mshr_ld_ack <= int'(3'(q_tail - q_head)) < 4 && ($urandom % 100) < ld_ack_pct;
		mshr_vld <= ($urandom % 100) < fill_pct;
		k = int'($urandom % 4);
		mshr_addr <= q_vld[k] ? q_addr[k] : pool[$urandom % 8];
		mshr_stall <= ($urandom % 8) == 0;
		dc_data <= {$urandom, $urandom};
		rs_pos <= 3'(m_head[2:0] + 3'($urandom % (cnt + 1)));
	endtask

	task automatic run_test(input string name, input int ld_ack, input int st_ack,
		input int br, input int fill);
		ld_ack_pct = ld_ack;
		st_ack_pct = st_ack;
		br_pct = br;
		fill_pct = fill;
		test_errors = 0;
		for (int c = 0; c < TEST_CYCLES; c++) begin
			@(posedge clk);
			advance_model();
			drive_inputs();
			@(negedge clk);
			predict_and_check();
		end
		$display("test %s finished after %0d cycles with %0d errors",
			name, TEST_CYCLES, test_errors);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h4425_f00e));
		clk = 1'b0;
		rst = 1'b1;
		{dp_en, st_vld, rob_st_retire_en, ld_vld, dc_hit} = '0;
		{mshr_ld_ack, mshr_st_ack, mshr_vld, mshr_stall} = '0;
		{br_recovery, br_pred_correct} = '0;
		sq_idx = '0;
		rs_pos = '0;
		ex_pos = '0;
		sq_tail_recovery = '0;
		addr = '0;
		mshr_addr = '0;
		st_data = '0;
		dc_data = '0;
		rob_idx = '0;
		dest_tag = '0;
		br_mask = '0;
		br_tag_fix = '0;
		errors = 0;
		checks = 0;
		// nonzero so unwritten load slots never match a fill
		for (int k = 0; k < 8; k++)
			pool[k] = 32'h8000_0040 + 32'(k * 8);
		reset_model();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		predict_and_check();

		run_test("mixed", 50, 50, 3, 30);
		run_test("back_pressure", 10, 10, 3, 10);
		run_test("branch_heavy", 60, 70, 15, 40);

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
src/lsq_pkg.sv
src/sq_lookup_if.sv
src/lq_alloc_if.sv
src/store_queue.sv
src/load_queue.sv
src/lsq_ctrl.sv
src/lsq_top.sv
testbench/lsq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load-store queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module lsq_tb -f flist.f -o lsq_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/lsq_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
	exit 0
fi
exit 1
